// File: common/axi_pkg.sv
package axi_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int ID_BITS    = 4;
    localparam int LEN_BITS   = 8;
    localparam int SIZE_BITS  = 3;

    // every beat is a full 32-bit word.
    localparam logic [SIZE_BITS-1:0] SIZE_WORD = 3'd2;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    localparam logic [ID_BITS-1:0] ID_CPU2MEM = 4'd1;  // line memory traffic.
    localparam logic [ID_BITS-1:0] ID_CPU2REG = 4'd2;  // register window traffic.

endpackage

// File: common/soc_map_pkg.sv
package soc_map_pkg;

    localparam int LINE_WIDTH = 128;
    localparam int LINE_BEATS = 4;
    localparam int BEAT_BITS  = $clog2(LINE_BEATS);

    // region field of the byte address.
    localparam int REGION_MSB = 19;
    localparam int REGION_LSB = 16;

    typedef enum logic [3:0] {
        REGION_MEM = 4'd0,
        REGION_DMA = 4'd1,  // not mapped in this system.
        REGION_REG = 4'd2
    } region_e;

    localparam int MEM_WORDS = 256;
    localparam int REG_WORDS = 4;
    localparam int WQ_DEPTH  = 4;

endpackage

// File: axi_master/line_write_queue.sv
module line_write_queue (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               push_i,
    input  logic                               pop_i,
    input  logic [axi_pkg::ADDR_WIDTH-1:0]     addr_i,
    input  logic [soc_map_pkg::LINE_WIDTH-1:0] line_i,
    output logic [axi_pkg::ADDR_WIDTH-1:0]     addr_o,
    output logic [soc_map_pkg::LINE_WIDTH-1:0] line_o,
    output logic                               full_o,
    output logic                               empty_o
);
    import axi_pkg::*;
    import soc_map_pkg::*;

    logic [ADDR_WIDTH-1:0] addr_mem [WQ_DEPTH];
    logic [LINE_WIDTH-1:0] line_mem [WQ_DEPTH];
    logic [$clog2(WQ_DEPTH)-1:0] wr_ptr;
    logic [$clog2(WQ_DEPTH)-1:0] rd_ptr;
    logic [$clog2(WQ_DEPTH):0] count;
    logic do_push;
    logic do_pop;

    assign full_o  = (count == WQ_DEPTH);
    assign empty_o = (count == 0);
    assign do_push = push_i && !full_o;   // overflow is dropped.
    assign do_pop  = pop_i && !empty_o;

    assign addr_o = addr_mem[rd_ptr];
    assign line_o = line_mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            addr_mem[wr_ptr] <= addr_i;
            line_mem[wr_ptr] <= line_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two.
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

// File: axi_master/axi_line_master.sv
module axi_line_master (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               cs_i,
    input  logic                               we_i,
    input  logic [axi_pkg::ADDR_WIDTH-1:0]     addr_i,
    input  logic [soc_map_pkg::LINE_WIDTH-1:0] wline_i,
    output logic [soc_map_pkg::LINE_WIDTH-1:0] rline_o,
    output logic                               rvalid_o,
    output logic                               rd_err_o,
    output logic                               wq_full_o,
    output logic                               wr_busy_o,
    output logic                               wr_err_o,
    output logic [axi_pkg::ID_BITS-1:0]        awid_o,
    output logic [axi_pkg::ADDR_WIDTH-1:0]     awaddr_o,
    output logic [axi_pkg::LEN_BITS-1:0]       awlen_o,
    output logic [axi_pkg::SIZE_BITS-1:0]      awsize_o,
    output axi_pkg::burst_e                    awburst_o,
    output logic                               awvalid_o,
    input  logic                               awready_i,
    output logic [axi_pkg::DATA_WIDTH-1:0]     wdata_o,
    output logic [axi_pkg::STRB_WIDTH-1:0]     wstrb_o,
    output logic                               wlast_o,
    output logic                               wvalid_o,
    input  logic                               wready_i,
    input  logic [axi_pkg::ID_BITS-1:0]        bid_i,
    input  axi_pkg::resp_e                     bresp_i,
    input  logic                               bvalid_i,
    output logic                               bready_o,
    output logic [axi_pkg::ID_BITS-1:0]        arid_o,
    output logic [axi_pkg::ADDR_WIDTH-1:0]     araddr_o,
    output logic [axi_pkg::LEN_BITS-1:0]       arlen_o,
    output logic [axi_pkg::SIZE_BITS-1:0]      arsize_o,
    output axi_pkg::burst_e                    arburst_o,
    output logic                               arvalid_o,
    input  logic                               arready_i,
    input  logic [axi_pkg::ID_BITS-1:0]        rid_i,
    input  logic [axi_pkg::DATA_WIDTH-1:0]     rdata_i,
    input  axi_pkg::resp_e                     rresp_i,
    input  logic                               rlast_i,
    input  logic                               rvalid_i,
    output logic                               rready_o
);
    import axi_pkg::*;
    import soc_map_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} wr_state_e;
    typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA} rd_state_e;

    wr_state_e w_state;
    rd_state_e r_state;
    logic wq_push;
    logic wq_pop;
    logic wq_empty;
    logic [ADDR_WIDTH-1:0] wq_addr;
    logic [LINE_WIDTH-1:0] wq_line;
    logic [ADDR_WIDTH-1:0] w_addr;
    logic [LINE_WIDTH-1:0] w_line;
    logic [ADDR_WIDTH-1:0] r_addr;
    logic [BEAT_BITS-1:0] w_beat;
    logic [BEAT_BITS-1:0] r_beat;
    logic w_is_reg;
    logic r_is_reg;
    logic rd_accept;
    logic r_hs;
    logic r_beat_err;
    logic r_err;

    assign wq_push = cs_i && we_i && !wq_full_o;
    assign wq_pop  = !wq_empty && (w_state == W_IDLE);  // awvalid is low in idle.

    line_write_queue u_wq (
        .clk_i,
        .rst_ni,
        .push_i  (wq_push),
        .pop_i   (wq_pop),
        .addr_i,
        .line_i  (wline_i),
        .addr_o  (wq_addr),
        .line_o  (wq_line),
        .full_o  (wq_full_o),
        .empty_o (wq_empty)
    );

    assign wr_busy_o = !wq_empty || (w_state != W_IDLE);

    always_ff @(posedge clk_i) begin
        if (wq_pop) begin
            w_addr <= wq_addr;
            w_line <= wq_line;
        end
    end

    // burst shape follows the region of the latched address.
    assign w_is_reg = (region_e'(w_addr[REGION_MSB:REGION_LSB]) == REGION_REG);

    always_comb begin
        awaddr_o = w_addr;
        awsize_o = SIZE_WORD;
        if (w_is_reg) begin
            awid_o    = ID_CPU2REG;
            awlen_o   = '0;
            awburst_o = BURST_FIXED;
        end else begin
            awid_o    = ID_CPU2MEM;  // unmapped regions look like memory.
            awlen_o   = LEN_BITS'(LINE_BEATS - 1);
            awburst_o = BURST_INCR;
        end
    end

    assign awvalid_o = (w_state == W_ADDR);
    assign wvalid_o  = (w_state == W_DATA);
    assign wdata_o   = w_line[w_beat*DATA_WIDTH +: DATA_WIDTH];
    assign wstrb_o   = '1;
    assign wlast_o   = wvalid_o && (w_beat == awlen_o[BEAT_BITS-1:0]);
    assign bready_o  = (w_state == W_RESP);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            w_state  <= W_IDLE;
            w_beat   <= '0;
            wr_err_o <= 1'b0;
        end else begin
            wr_err_o <= 1'b0;
            case (w_state)
                W_IDLE: begin
                    if (wq_pop) begin
                        w_state <= W_ADDR;
                        w_beat  <= '0;
                    end
                end
                W_ADDR: if (awready_i) w_state <= W_DATA;
                W_DATA: begin
                    if (wready_i) begin
                        w_beat <= w_beat + 1'b1;
                        if (wlast_o) w_state <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (bvalid_i) begin
                        wr_err_o <= (bresp_i != RESP_OKAY) || (bid_i != awid_o);
                        w_state  <= W_IDLE;
                    end
                end
                default: w_state <= W_IDLE;
            endcase
        end
    end

    assign rd_accept  = cs_i && !we_i && (r_state == R_IDLE);
    assign r_hs       = rvalid_i && rready_o;
    assign r_beat_err = (rresp_i != RESP_OKAY) || (rid_i != arid_o);
    assign r_is_reg   = (region_e'(r_addr[REGION_MSB:REGION_LSB]) == REGION_REG);

    always_comb begin
        araddr_o = r_addr;
        arsize_o = SIZE_WORD;
        if (r_is_reg) begin
            arid_o    = ID_CPU2REG;
            arlen_o   = '0;
            arburst_o = BURST_FIXED;
        end else begin
            arid_o    = ID_CPU2MEM;
            arlen_o   = LEN_BITS'(LINE_BEATS - 1);
            arburst_o = BURST_INCR;
        end
    end

    assign arvalid_o = (r_state == R_ADDR);
    assign rready_o  = (r_state == R_DATA);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            r_state  <= R_IDLE;
            r_beat   <= '0;
            r_err    <= 1'b0;
            rvalid_o <= 1'b0;
            rd_err_o <= 1'b0;
        end else begin
            rvalid_o <= 1'b0;
            rd_err_o <= 1'b0;
            case (r_state)
                R_IDLE: begin
                    if (rd_accept) begin
                        r_state <= R_ADDR;
                        r_beat  <= '0;
                        r_err   <= 1'b0;
                    end
                end
                R_ADDR: if (arready_i) r_state <= R_DATA;
                R_DATA: begin
                    if (r_hs) begin
                        r_beat <= r_beat + 1'b1;
                        r_err  <= r_err || r_beat_err;
                        if (rlast_i) begin
                            r_state  <= R_IDLE;
                            rvalid_o <= 1'b1;
                            rd_err_o <= r_err || r_beat_err;
                        end
                    end
                end
                default: r_state <= R_IDLE;
            endcase
        end
    end

    // line is cleared on accept so a single-beat read leaves words 1 to 3 zero.
    always_ff @(posedge clk_i) begin
        if (rd_accept) begin
            r_addr  <= addr_i;
            rline_o <= '0;
        end else if (r_hs) begin
            rline_o[r_beat*DATA_WIDTH +: DATA_WIDTH] <= rdata_i;
        end
    end

endmodule

// File: verilog/axi_mem_target.sv
module axi_mem_target (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [axi_pkg::ID_BITS-1:0]    awid_i,
    input  logic [axi_pkg::ADDR_WIDTH-1:0] awaddr_i,
    input  logic [axi_pkg::LEN_BITS-1:0]   awlen_i,
    input  logic [axi_pkg::SIZE_BITS-1:0]  awsize_i,
    input  axi_pkg::burst_e                awburst_i,
    input  logic                           awvalid_i,
    output logic                           awready_o,
    input  logic [axi_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic [axi_pkg::STRB_WIDTH-1:0] wstrb_i,
    input  logic                           wlast_i,
    input  logic                           wvalid_i,
    output logic                           wready_o,
    output logic [axi_pkg::ID_BITS-1:0]    bid_o,
    output axi_pkg::resp_e                 bresp_o,
    output logic                           bvalid_o,
    input  logic                           bready_i,
    input  logic [axi_pkg::ID_BITS-1:0]    arid_i,
    input  logic [axi_pkg::ADDR_WIDTH-1:0] araddr_i,
    input  logic [axi_pkg::LEN_BITS-1:0]   arlen_i,
    input  logic [axi_pkg::SIZE_BITS-1:0]  arsize_i,
    input  axi_pkg::burst_e                arburst_i,
    input  logic                           arvalid_i,
    output logic                           arready_o,
    output logic [axi_pkg::ID_BITS-1:0]    rid_o,
    output logic [axi_pkg::DATA_WIDTH-1:0] rdata_o,
    output axi_pkg::resp_e                 rresp_o,
    output logic                           rlast_o,
    output logic                           rvalid_o,
    input  logic                           rready_i
);
    import axi_pkg::*;
    import soc_map_pkg::*;

    typedef enum logic [1:0] {TW_IDLE, TW_DATA, TW_RESP} tw_state_e;
    typedef enum logic {TR_IDLE, TR_DATA} tr_state_e;

    tw_state_e w_state;
    tr_state_e r_state;
    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
    logic [DATA_WIDTH-1:0] regs [REG_WORDS];
    logic [ADDR_WIDTH-1:0] aw_addr;
    logic [ADDR_WIDTH-1:0] ar_addr;
    logic [ID_BITS-1:0] aw_id;
    logic [ID_BITS-1:0] ar_id;
    logic [LEN_BITS-1:0] aw_len;
    logic [LEN_BITS-1:0] ar_len;
    burst_e aw_burst;
    burst_e ar_burst;
    logic aw_bad;
    logic ar_bad;
    logic [LEN_BITS-1:0] w_cnt;
    logic [LEN_BITS-1:0] r_cnt;
    region_e w_region;
    region_e r_region;
    logic [$clog2(MEM_WORDS)-1:0] w_idx;
    logic [$clog2(MEM_WORDS)-1:0] r_idx;
    logic w_hs;

    assign w_region = region_e'(aw_addr[REGION_MSB:REGION_LSB]);
    assign r_region = region_e'(ar_addr[REGION_MSB:REGION_LSB]);
    // line from bits 9:4, word from the beat count on incrementing bursts.
    assign w_idx = {aw_addr[9:4], (aw_burst == BURST_INCR) ? w_cnt[BEAT_BITS-1:0] : 2'b00};
    assign r_idx = {ar_addr[9:4], (ar_burst == BURST_INCR) ? r_cnt[BEAT_BITS-1:0] : 2'b00};

    assign awready_o = (w_state == TW_IDLE);
    assign wready_o  = (w_state == TW_DATA);
    assign bvalid_o  = (w_state == TW_RESP);
    assign bid_o     = aw_id;
    assign w_hs      = wvalid_i && wready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            w_state <= TW_IDLE;
            w_cnt   <= '0;
        end else begin
            case (w_state)
                TW_IDLE: begin
                    if (awvalid_i) begin
                        w_state <= TW_DATA;
                        w_cnt   <= '0;
                    end
                end
                TW_DATA: begin
                    if (wvalid_i) begin
                        w_cnt <= w_cnt + 1'b1;
                        if (wlast_i) w_state <= TW_RESP;
                    end
                end
                TW_RESP: if (bready_i) w_state <= TW_IDLE;
                default: w_state <= TW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (awvalid_i && awready_o) begin
            aw_addr  <= awaddr_i;
            aw_id    <= awid_i;
            aw_len   <= awlen_i;
            aw_burst <= awburst_i;
            aw_bad   <= (awsize_i != SIZE_WORD);
        end else if (w_hs && wlast_i && (w_cnt != aw_len)) begin
            aw_bad <= 1'b1;  // wlast out of step with awlen.
        end
    end

    // unmapped writes fall through untouched.
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (w_hs && wstrb_i[b] && (w_region == REGION_MEM))
                mem[w_idx][8*b +: 8] <= wdata_i[8*b +: 8];
            if (w_hs && wstrb_i[b] && (w_region == REGION_REG))
                regs[aw_addr[3:2]][8*b +: 8] <= wdata_i[8*b +: 8];
        end
    end

    always_comb begin
        if (w_region != REGION_MEM && w_region != REGION_REG) bresp_o = RESP_DECERR;
        else if (aw_bad) bresp_o = RESP_SLVERR;
        else bresp_o = RESP_OKAY;
    end

    assign arready_o = (r_state == TR_IDLE);
    assign rvalid_o  = (r_state == TR_DATA);
    assign rlast_o   = rvalid_o && (r_cnt == ar_len);
    assign rid_o     = ar_id;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            r_state <= TR_IDLE;
            r_cnt   <= '0;
        end else begin
            case (r_state)
                TR_IDLE: begin
                    if (arvalid_i) begin
                        r_state <= TR_DATA;
                        r_cnt   <= '0;
                    end
                end
                TR_DATA: begin
                    if (rready_i) begin
                        r_cnt <= r_cnt + 1'b1;
                        if (rlast_o) r_state <= TR_IDLE;
                    end
                end
                default: r_state <= TR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (arvalid_i && arready_o) begin
            ar_addr  <= araddr_i;
            ar_id    <= arid_i;
            ar_len   <= arlen_i;
            ar_burst <= arburst_i;
            ar_bad   <= (arsize_i != SIZE_WORD);
        end
    end

    always_comb begin
        rdata_o = '0;  // unmapped reads return zero.
        rresp_o = RESP_DECERR;
        if (r_region == REGION_MEM) begin
            rdata_o = mem[r_idx];
            rresp_o = ar_bad ? RESP_SLVERR : RESP_OKAY;
        end else if (r_region == REGION_REG) begin
            rdata_o = regs[ar_addr[3:2]];
            rresp_o = ar_bad ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

// File: verilog/cpu_axi_top.sv
module cpu_axi_top (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               cs_i,
    input  logic                               we_i,
    input  logic [axi_pkg::ADDR_WIDTH-1:0]     addr_i,
    input  logic [soc_map_pkg::LINE_WIDTH-1:0] wline_i,
    output logic [soc_map_pkg::LINE_WIDTH-1:0] rline_o,
    output logic                               rvalid_o,
    output logic                               rd_err_o,
    output logic                               wq_full_o,
    output logic                               wr_busy_o,
    output logic                               wr_err_o
);
    import axi_pkg::*;

    logic [ID_BITS-1:0] awid, bid, arid, rid;
    logic [ADDR_WIDTH-1:0] awaddr, araddr;
    logic [LEN_BITS-1:0] awlen, arlen;
    logic [SIZE_BITS-1:0] awsize, arsize;
    burst_e awburst, arburst;
    logic [DATA_WIDTH-1:0] wdata, rdata;
    logic [STRB_WIDTH-1:0] wstrb;
    resp_e bresp, rresp;
    logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rlast, rvalid, rready;

    axi_line_master u_master (
        .clk_i, .rst_ni, .cs_i, .we_i, .addr_i, .wline_i,
        .rline_o, .rvalid_o, .rd_err_o, .wq_full_o, .wr_busy_o, .wr_err_o,
        .awid_o (awid), .awaddr_o (awaddr), .awlen_o (awlen), .awsize_o (awsize),
        .awburst_o (awburst), .awvalid_o (awvalid), .awready_i (awready),
        .wdata_o (wdata), .wstrb_o (wstrb), .wlast_o (wlast),
        .wvalid_o (wvalid), .wready_i (wready),
        .bid_i (bid), .bresp_i (bresp), .bvalid_i (bvalid), .bready_o (bready),
        .arid_o (arid), .araddr_o (araddr), .arlen_o (arlen), .arsize_o (arsize),
        .arburst_o (arburst), .arvalid_o (arvalid), .arready_i (arready),
        .rid_i (rid), .rdata_i (rdata), .rresp_i (rresp), .rlast_i (rlast),
        .rvalid_i (rvalid), .rready_o (rready)
    );

    axi_mem_target u_target (
        .clk_i, .rst_ni,
        .awid_i (awid), .awaddr_i (awaddr), .awlen_i (awlen), .awsize_i (awsize),
        .awburst_i (awburst), .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i (wdata), .wstrb_i (wstrb), .wlast_i (wlast),
        .wvalid_i (wvalid), .wready_o (wready),
        .bid_o (bid), .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
        .arid_i (arid), .araddr_i (araddr), .arlen_i (arlen), .arsize_i (arsize),
        .arburst_i (arburst), .arvalid_i (arvalid), .arready_o (arready),
        .rid_o (rid), .rdata_o (rdata), .rresp_o (rresp), .rlast_o (rlast),
        .rvalid_o (rvalid), .rready_i (rready)
    );

endmodule

// File: bench/cpu_axi_chk.sv
module cpu_axi_chk (
    input logic clk_i,
    input logic rst_ni,
    input logic awvalid_i,
    input logic awready_i,
    input logic arvalid_i,
    input logic arready_i,
    input logic wvalid_i,
    input logic wlast_i,
    input logic rvalid_i,
    input logic w_idle_i
);

    int fail_count = 0;

    // address valid stays up until the target takes it.
    aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        awvalid_i && !awready_i |=> awvalid_i)
        else begin
            $error("awvalid dropped before awready");
            fail_count++;
        end

    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        arvalid_i && !arready_i |=> arvalid_i)
        else begin
            $error("arvalid dropped before arready");
            fail_count++;
        end

    wlast_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wlast_i |-> wvalid_i)
        else begin
            $error("wlast without wvalid");
            fail_count++;
        end

    rvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i |=> !rvalid_i)
        else begin
            $error("rvalid held for two cycles");
            fail_count++;
        end

    no_data_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wvalid_i |-> !w_idle_i)
        else begin
            $error("wvalid while write engine idle");
            fail_count++;
        end

endmodule

bind axi_line_master cpu_axi_chk u_chk (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .awvalid_i (awvalid_o),
    .awready_i (awready_i),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .wvalid_i  (wvalid_o),
    .wlast_i   (wlast_o),
    .rvalid_i  (rvalid_o),
    .w_idle_i  (w_state == W_IDLE)
);

// File: bench/tb_cpu_axi_top.sv
module tb_cpu_axi_top;
    import axi_pkg::*;
    import soc_map_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int OP_WRITE   = 0;
    localparam int OP_READ    = 1;
    localparam int OP_GROUP   = 2;

    logic clk_i;
    logic rst_ni;
    logic cs_i;
    logic we_i;
    logic [ADDR_WIDTH-1:0] addr_i;
    logic [LINE_WIDTH-1:0] wline_i;
    logic [LINE_WIDTH-1:0] rline_o;
    logic rvalid_o;
    logic rd_err_o;
    logic wq_full_o;
    logic wr_busy_o;
    logic wr_err_o;

    logic [31:0] lfsr;
    logic [DATA_WIDTH-1:0] mem_model [MEM_WORDS];
    logic [DATA_WIDTH-1:0] reg_model [REG_WORDS];
    int errors;
    int checks;
    int timeouts;

    // stimulus table, one step per index.
    int op_q[$];
    logic [3:0] region_q[$];
    int off_q[$];
    int n_q[$];
    bit err_q[$];
    string name_q[$];

    cpu_axi_top u_cpu_axi_top (
        .clk_i, .rst_ni, .cs_i, .we_i, .addr_i, .wline_i,
        .rline_o, .rvalid_o, .rd_err_o, .wq_full_o, .wr_busy_o, .wr_err_o
    );

    always #10 clk_i = ~clk_i;

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [3:0] region, input int off);
        logic [ADDR_WIDTH-1:0] a;
        a = '0;
        a[REGION_MSB:REGION_LSB] = region;
        if (region == REGION_REG) a[3:2] = off[1:0];
        else a[9:4] = off[5:0];
        return a;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] expect_line(input logic [3:0] region, input int off);
        logic [LINE_WIDTH-1:0] line;
        line = '0;
        if (region == REGION_MEM) begin
            for (int k = 0; k < LINE_BEATS; k++) begin
                line[k*DATA_WIDTH +: DATA_WIDTH] = mem_model[off*4 + k];
            end
        end else if (region == REGION_REG) begin
            line[DATA_WIDTH-1:0] = reg_model[off % REG_WORDS];  // single beat only.
        end
        return line;
    endfunction

    task automatic add_step(input int op, input logic [3:0] region, input int off, input int n,
                            input bit err, input string name);
        op_q.push_back(op);
        region_q.push_back(region);
        off_q.push_back(off);
        n_q.push_back(n);
        err_q.push_back(err);
        name_q.push_back(name);
    endtask

    task automatic push_line(input logic [3:0] region, input int off, input bit check_full,
                             input string name);
        logic [LINE_WIDTH-1:0] line;
        int t;
        for (int i = 0; i < LINE_WIDTH; i++) begin
            lfsr = lfsr_next(lfsr);
            line[i] = lfsr[0];
        end
        if (check_full && wq_full_o) begin
            errors++;
            $display("ERR %s wq_full expected 0 actual 1", name);
        end
        t = 0;
        while (wq_full_o && t < WAIT_LIMIT) begin
            @(negedge clk_i);
            t++;
        end
        if (wq_full_o) begin
            timeouts++;
            $display("timeout: write queue of %s never left the full state", name);
        end
        cs_i    = 1'b1;
        we_i    = 1'b1;
        addr_i  = make_addr(region, off);
        wline_i = line;
        if (region == REGION_MEM) begin
            for (int k = 0; k < LINE_BEATS; k++) begin
                mem_model[off*4 + k] = line[k*DATA_WIDTH +: DATA_WIDTH];
            end
        end else if (region == REGION_REG) begin
            reg_model[off % REG_WORDS] = line[DATA_WIDTH-1:0];
        end
        @(negedge clk_i);
    endtask

    task automatic wait_write_done(input bit exp_err, input string name);
        bit seen;
        int t;
        seen = 1'b0;
        t = 0;
        while (wr_busy_o && t < WAIT_LIMIT) begin
            @(negedge clk_i);
            seen |= wr_err_o;  // error pulse lands with the last response.
            t++;
        end
        if (wr_busy_o) begin
            timeouts++;
            $display("timeout: write path of %s never went idle", name);
        end
        checks++;
        if (seen !== exp_err) begin
            errors++;
            $display("ERR %s wr_err expected %0b actual %0b", name, exp_err, seen);
        end
    endtask

    task automatic do_read(input logic [3:0] region, input int off, input bit exp_err,
                           input string name);
        logic [LINE_WIDTH-1:0] exp_line;
        int t;
        exp_line = expect_line(region, off);
        cs_i   = 1'b1;
        we_i   = 1'b0;
        addr_i = make_addr(region, off);
        @(negedge clk_i);
        cs_i = 1'b0;
        t = 0;
        while (!rvalid_o && t < WAIT_LIMIT) begin
            @(negedge clk_i);
            t++;
        end
        if (!rvalid_o) begin
            timeouts++;
            $display("timeout: read of %s never returned a line", name);
        end else begin
            checks++;
            if (rline_o !== exp_line) begin
                errors++;
                $display("ERR %s rline expected %h actual %h", name, exp_line, rline_o);
            end
            if (rd_err_o !== exp_err) begin
                errors++;
                $display("ERR %s rd_err expected %0b actual %0b", name, exp_err, rd_err_o);
            end
        end
    endtask

    initial begin
        int cnt;
        clk_i    = 1'b0;
        rst_ni   = 1'b0;
        cs_i     = 1'b0;
        we_i     = 1'b0;
        addr_i   = '0;
        wline_i  = '0;
        lfsr     = 32'h12c79912;
        errors   = 0;
        checks   = 0;
        timeouts = 0;

        add_step(OP_WRITE, 4'd0, 3, 1, 1'b0, "mem_write_l3");
        add_step(OP_READ,  4'd0, 3, 1, 1'b0, "mem_read_l3");
        add_step(OP_WRITE, 4'd2, 1, 1, 1'b0, "reg_write_r1");
        add_step(OP_READ,  4'd2, 1, 1, 1'b0, "reg_read_r1");
        add_step(OP_GROUP, 4'd0, 8, 4, 1'b0, "group_write_l8");
        add_step(OP_READ,  4'd0, 8, 1, 1'b0, "group_read_l8");
        add_step(OP_READ,  4'd0, 9, 1, 1'b0, "group_read_l9");
        add_step(OP_READ,  4'd0, 10, 1, 1'b0, "group_read_l10");
        add_step(OP_READ,  4'd0, 11, 1, 1'b0, "group_read_l11");
        add_step(OP_WRITE, 4'd1, 3, 1, 1'b1, "dma_write_l3");
        add_step(OP_WRITE, 4'd5, 8, 1, 1'b1, "region5_write_l8");
        add_step(OP_READ,  4'd1, 3, 1, 1'b1, "dma_read_l3");
        add_step(OP_READ,  4'd5, 0, 1, 1'b1, "region5_read_l0");
        add_step(OP_READ,  4'd0, 3, 1, 1'b0, "mem_kept_l3");
        add_step(OP_READ,  4'd0, 8, 1, 1'b0, "mem_kept_l8");
        add_step(OP_WRITE, 4'd2, 3, 1, 1'b0, "reg_write_r3");
        add_step(OP_READ,  4'd2, 3, 1, 1'b0, "reg_read_r3");
        add_step(OP_READ,  4'd2, 1, 1, 1'b0, "reg_kept_r1");

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        checks++;
        if (rvalid_o || wr_busy_o || wr_err_o || wq_full_o) begin
            errors++;
            $display("ERR reset_idle expected 0000 actual %b%b%b%b",
                     rvalid_o, wr_busy_o, wr_err_o, wq_full_o);
        end

        for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == OP_READ) begin
                do_read(region_q[i], off_q[i], err_q[i], name_q[i]);
            end else begin
                cnt = (op_q[i] == OP_GROUP) ? n_q[i] : 1;
                for (int j = 0; j < cnt; j++) begin
                    push_line(region_q[i], off_q[i] + j, op_q[i] == OP_GROUP, name_q[i]);
                end
                cs_i = 1'b0;
                we_i = 1'b0;
                wait_write_done(err_q[i], name_q[i]);
            end
        end

        errors += u_cpu_axi_top.u_master.u_chk.fail_count;
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: build.f
common/axi_pkg.sv
common/soc_map_pkg.sv
axi_master/line_write_queue.sv
axi_master/axi_line_master.sv
verilog/axi_mem_target.sv
verilog/cpu_axi_top.sv
bench/cpu_axi_chk.sv
bench/tb_cpu_axi_top.sv
